// ==== Makefile ====
# Verilator run of the keypad calculator testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_calc -Mdir obj_dir
	./obj_dir/Vtb_calc | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== calc_checker.sv ====
module calc_checker (
    input  logic               clk,
    input  logic               nRST,
    input  logic               check,      // one cycle strobe from the stimulus loop
    input  calc_pkg::operand_t expected,
    input  calc_pkg::operand_t display,
    input  calc_pkg::col_t     col_out
);

    int checks = 0;
    int errors = 0;

    // display clear and idle column scan right after reset
    initial begin : startup_scan
        calc_pkg::col_t seen;
        seen = '0;
        @(posedge nRST);
        @(posedge clk);
        checks++;
        if (display !== '0) begin
            $display("[ERROR] display after reset: expected %h, got %h",
                     16'h0000, display);
            errors++;
        end
        repeat (8) begin
            if (!$onehot(~col_out)) begin
                $display("[ERROR] col_out: expected one low bit, got %h", col_out);
                errors++;
            end
            seen = seen | ~col_out;      // columns driven so far
            @(posedge clk);
        end
        checks++;
        if (seen != '1) begin
            $display("column scan did not reach all four columns while idle");
            errors++;
        end
    end

    // display is quiet by the time the strobe comes
    always @(posedge clk) begin
        if (nRST && check) begin
            checks++;
            if (display !== expected) begin
                $display("[ERROR] display: expected %h, got %h (check %0d)",
                         expected, display, checks);
                errors++;
            end
        end
    end

endmodule

// ==== calc_controller.sv ====
module calc_controller (
    input  logic               clk,
    input  logic               nRST,
    key_if.controller          key,
    output calc_pkg::operand_t display    // entry while typing, else result
);

    calc_pkg::operand_t entry;             // operand being typed
    calc_pkg::operand_t acc;               // running result
    logic               entry_started;     // at least one digit since last op
    calc_pkg::calc_op_t pending;           // operator waiting for its right side
    logic               take_key;          // key accepted this cycle
    logic               do_pending;        // pending op has both operands
    calc_pkg::operand_t result;            // acc pending entry

    // add/sub/mul, all modulo 2^16
    function automatic calc_pkg::operand_t apply_op(input calc_pkg::calc_op_t op,
                                                    input calc_pkg::operand_t a,
                                                    input calc_pkg::operand_t b);
        calc_pkg::operand_t res;
        case (op)
            calc_pkg::OP_ADD: res = a + b;
            calc_pkg::OP_SUB: res = a - b;
            calc_pkg::OP_MUL: res = a * b;       // low half of product
            default:          res = a;
        endcase
        return res;
    endfunction

    assign take_key   = key.key_rdy && !key.key_rd;   // once per offered key
    assign do_pending = (pending != calc_pkg::OP_NONE) && entry_started;
    assign result     = apply_op(pending, acc, entry);
    assign display    = entry_started ? entry : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry         <= '0;
            acc           <= '0;
            entry_started <= 1'b0;
            pending       <= calc_pkg::OP_NONE;
            key.key_rd    <= 1'b0;
        end else begin
            key.key_rd <= take_key;            // one cycle strobe

            if (take_key) begin
                if (key.digit != calc_pkg::DIGIT_NONE) begin
                    // a fresh entry starts from zero, even after '='
                    entry <= (entry_started ? entry * 16'd10 : '0) +
                             calc_pkg::operand_t'(key.digit);
                    entry_started <= 1'b1;
                end else if (key.equal) begin
                    if (do_pending) begin
                        acc <= result;
                    end else if (entry_started) begin
                        acc <= entry;          // plain number then '='
                    end
                    pending       <= calc_pkg::OP_NONE;
                    entry_started <= 1'b0;
                end else begin
                    case (key.op)
                        calc_pkg::OP_ADD,
                        calc_pkg::OP_SUB,
                        calc_pkg::OP_MUL: begin
                            if (do_pending) begin
                                acc <= result;         // chain left to right
                            end else if (entry_started) begin
                                acc <= entry;          // first operand
                            end
                            pending       <= key.op;   // last operator wins
                            entry         <= '0;
                            entry_started <= 1'b0;
                        end
                        calc_pkg::OP_NEG: begin
                            if (entry_started) begin
                                entry <= -entry;
                            end else begin
                                acc <= -acc;           // sign of shown result
                            end
                        end
                        default: ;                     // '#' key, no field set
                    endcase
                end
            end
        end
    end

    // strobe only while a key is on offer
    a_rd_in_rdy: assert property (@(posedge clk) disable iff (!nRST)
        key.key_rd |-> key.key_rdy)
        else $error("key_rd high without key_rdy");

endmodule

// ==== calc_pkg.sv ====
package calc_pkg;

    // keypad geometry
    localparam int NUM_ROWS = 4;                 // rows read back, pulled up
    localparam int NUM_COLS = 4;                 // columns driven low one at a time

    // debounce
    localparam int DEBOUNCE_CYCLES = 10;         // stable low cycles before confirm
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_CYCLES);

    // arithmetic width
    localparam int OPERAND_W = 16;               // two's complement, wraps

    typedef logic [NUM_ROWS-1:0]          row_t;       // active low rows
    typedef logic [NUM_COLS-1:0]          col_t;       // one bit low
    typedef logic [$clog2(NUM_COLS)-1:0]  col_sel_t;   // active column number
    typedef logic [DEB_CNT_W-1:0]         deb_cnt_t;   // debounce counter
    typedef logic [3:0]                   key_idx_t;   // row*4 + col
    typedef logic [3:0]                   digit_t;     // 0..9, 15 = none
    typedef logic [OPERAND_W-1:0]         operand_t;   // entry, acc, display

    localparam digit_t DIGIT_NONE = 4'd15;       // key carries no digit

    // operator codes as the keypad decoder emits them
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,                          // change sign
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

    // key indices that are not plain digits 1..9
    localparam key_idx_t KEY_ADD   = 4'd3;       // A
    localparam key_idx_t KEY_SUB   = 4'd7;       // B
    localparam key_idx_t KEY_MUL   = 4'd11;      // C
    localparam key_idx_t KEY_EQUAL = 4'd12;      // '*'
    localparam key_idx_t KEY_ZERO  = 4'd13;      // digit 0
    localparam key_idx_t KEY_HASH  = 4'd14;      // '#', no function
    localparam key_idx_t KEY_NEG   = 4'd15;      // D

endpackage

// ==== calc_top.sv ====
module calc_top (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::row_t     row_in,    // keypad rows, pulled up
    output calc_pkg::col_t     col_out,   // keypad column drive
    output calc_pkg::operand_t display    // 16-bit two's complement value
);

    key_if u_key ();                      // key bus, scanner to controller

    input_control u_scan (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key     (u_key.scanner)
    );

    calc_controller u_ctrl (
        .clk     (clk),
        .nRST    (nRST),
        .key     (u_key.controller),
        .display (display)
    );

endmodule

// ==== input_control.sv ====
module input_control (
    input  logic           clk,
    input  logic           nRST,
    input  calc_pkg::row_t row_in,    // pulled up, low when pressed
    output calc_pkg::col_t col_out,   // one column low at a time
    key_if.scanner         key
);

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_t;

    scan_state_t         state;
    scan_state_t         next_state;
    calc_pkg::col_sel_t  col_sel;     // column being driven
    calc_pkg::deb_cnt_t  deb_cnt;     // consecutive low cycles
    calc_pkg::key_idx_t  key_idx;     // latched on the last stable cycle
    logic                row_low;     // some row reads low
    logic                deb_done;    // stable run complete

    // first (lowest) low row wins
    function automatic calc_pkg::key_idx_t encode_key(input calc_pkg::row_t   row,
                                                      input calc_pkg::col_sel_t col);
        calc_pkg::key_idx_t idx;
        idx = '0;
        for (int r = calc_pkg::NUM_ROWS - 1; r >= 0; r--) begin
            if (!row[r]) begin
                idx = calc_pkg::key_idx_t'(r * calc_pkg::NUM_COLS + int'(col));
            end
        end
        return idx;
    endfunction

    assign row_low  = ~&row_in;
    assign deb_done = (state == WAIT_STABLE) && row_low &&
                      (deb_cnt == calc_pkg::deb_cnt_t'(calc_pkg::DEBOUNCE_CYCLES - 1));

    always_comb begin
        col_out          = '1;
        col_out[col_sel] = 1'b0;              // drive active column low
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:         next_state = SCAN_COL;
            SCAN_COL:     next_state = row_low ? WAIT_STABLE : SCAN_COL;   // freeze column
            WAIT_STABLE:  next_state = deb_done ? CONFIRM : WAIT_STABLE;   // bounce just restarts
            CONFIRM:      next_state = WAIT_RELEASE;
            WAIT_RELEASE: begin
                // key must be read and released before scanning on
                if (!key.key_rdy && !row_low) begin
                    next_state = IDLE;
                end
            end
            default:      next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE;
            col_sel     <= '0;                 // column 0 low after reset
            deb_cnt     <= '0;
            key.key_rdy <= 1'b0;
        end else begin
            state <= next_state;

            if (state == SCAN_COL && !row_low) begin
                col_sel <= col_sel + 1'b1;     // wraps 3 -> 0
            end

            if (state == WAIT_STABLE && row_low && !deb_done) begin
                deb_cnt <= deb_cnt + 1'b1;
            end else begin
                deb_cnt <= '0;                 // row went high or run done
            end

            if (state == CONFIRM) begin
                key.key_rdy <= 1'b1;           // fields valid from this edge
            end else if (key.key_rd) begin
                key.key_rdy <= 1'b0;           // drop the cycle after the read
            end
        end
    end

    // key index and decoded fields
    always_ff @(posedge clk) begin
        if (deb_done) begin
            key_idx <= encode_key(row_in, col_sel);
        end

        if (state == CONFIRM) begin
            key.digit <= calc_pkg::DIGIT_NONE;
            key.op    <= calc_pkg::OP_NONE;
            key.equal <= 1'b0;
            case (key_idx)
                4'd0:                key.digit <= 4'd1;
                4'd1:                key.digit <= 4'd2;
                4'd2:                key.digit <= 4'd3;
                calc_pkg::KEY_ADD:   key.op    <= calc_pkg::OP_ADD;
                4'd4:                key.digit <= 4'd4;
                4'd5:                key.digit <= 4'd5;
                4'd6:                key.digit <= 4'd6;
                calc_pkg::KEY_SUB:   key.op    <= calc_pkg::OP_SUB;
                4'd8:                key.digit <= 4'd7;
                4'd9:                key.digit <= 4'd8;
                4'd10:               key.digit <= 4'd9;
                calc_pkg::KEY_MUL:   key.op    <= calc_pkg::OP_MUL;
                calc_pkg::KEY_EQUAL: key.equal <= 1'b1;
                calc_pkg::KEY_ZERO:  key.digit <= 4'd0;
                calc_pkg::KEY_HASH:  ;                          // all fields stay empty
                calc_pkg::KEY_NEG:   key.op    <= calc_pkg::OP_NEG;
            endcase
        end
    end

    // exactly one column driven low at all times
    a_col_onehot: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out))
        else $error("col_out does not drive exactly one column low");

    // read strobe retires the key on the next cycle
    a_rdy_drop: assert property (@(posedge clk) disable iff (!nRST)
        key.key_rd |=> !key.key_rdy)
        else $error("key_rdy still high the cycle after key_rd");

    // column only moves while scanning
    a_col_hold: assert property (@(posedge clk) disable iff (!nRST)
        (state != SCAN_COL) |=> $stable(col_sel))
        else $error("column changed outside SCAN_COL");

endmodule

// ==== key_if.sv ====
interface key_if;

    logic               key_rdy;   // scanner holds a decoded key
    logic               key_rd;    // one cycle pulse, key taken
    calc_pkg::digit_t   digit;     // DIGIT_NONE if not a digit key
    calc_pkg::calc_op_t op;        // OP_NONE if not an operator key
    logic               equal;     // '*' pressed

    // keypad side, offers the key and waits for the read strobe
    modport scanner (
        output key_rdy,
        output digit,
        output op,
        output equal,
        input  key_rd
    );

    // calculator side
    modport controller (
        input  key_rdy,
        input  digit,
        input  op,
        input  equal,
        output key_rd
    );

endinterface

// ==== tb_calc.sv ====
module tb_calc;

    logic               clk;
    logic               nRST;
    calc_pkg::row_t     row_in;
    calc_pkg::col_t     col_out;
    calc_pkg::operand_t display;

    logic               pressed;        // key held down on the keypad model
    calc_pkg::key_idx_t held_idx;       // which key is held
    logic               check;          // strobe to the checker
    calc_pkg::operand_t expected;       // value the checker compares against
    int                 seed;           // $random state
    int                 timeout_cycles;

    // stimulus table with one row per key press
    calc_pkg::key_idx_t step_key[$];
    int                 step_bounce[$];
    calc_pkg::operand_t step_exp[$];

    calc_top u_dut (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .display (display)
    );

    calc_checker u_chk (
        .clk      (clk),
        .nRST     (nRST),
        .check    (check),
        .expected (expected),
        .display  (display),
        .col_out  (col_out)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;              // period 100

    // 4x4 matrix pulls a row low only while its key's column is driven
    always_comb begin
        row_in = '1;
        if (pressed && !col_out[held_idx[1:0]]) begin
            row_in[held_idx[3:2]] = 1'b0;
        end
    end

    task automatic add_step(input calc_pkg::key_idx_t key, input int bounces,
                            input calc_pkg::operand_t exp_val);
        step_key.push_back(key);
        step_bounce.push_back(bounces);
        step_exp.push_back(exp_val);
    endtask

    // key index, bounces, display once the key is taken
    task automatic load_table();
        add_step(4'd0,  0, 16'h0001);   // 1
        add_step(4'd1,  1, 16'h000C);   // 12
        add_step(4'd2,  0, 16'h007B);   // 123
        add_step(4'd13, 1, 16'h04CE);   // 1230
        add_step(4'd12, 0, 16'h04CE);   // '=' on a plain number
        add_step(4'd0,  0, 16'h0001);   // fresh entry after '='
        add_step(4'd1,  2, 16'h000C);   // 12
        add_step(4'd3,  0, 16'h000C);   // + takes first operand
        add_step(4'd2,  1, 16'h0003);
        add_step(4'd13, 0, 16'h001E);   // 30
        add_step(4'd7,  0, 16'h002A);   // - shows 12+30
        add_step(4'd1,  2, 16'h0002);
        add_step(4'd11, 0, 16'h0028);   // x shows 42-2
        add_step(4'd2,  0, 16'h0003);
        add_step(4'd12, 1, 16'h0078);   // = shows 40*3
        add_step(4'd15, 0, 16'hFF88);   // negate result to -120
        add_step(4'd4,  0, 16'h0004);
        add_step(4'd5,  1, 16'h002D);   // 45
        add_step(4'd6,  0, 16'h01C8);   // 456
        add_step(4'd15, 2, 16'hFE38);   // negate entry to -456
        add_step(4'd12, 0, 16'hFE38);
        add_step(4'd5,  2, 16'h0005);
        add_step(4'd5,  2, 16'h0037);   // 55 with one key per press
        add_step(4'd8,  0, 16'h022D);   // 557
        add_step(4'd9,  1, 16'h15CA);   // 5578
        add_step(4'd10, 0, 16'hD9ED);   // 55789 sets the top bit
        add_step(4'd12, 0, 16'hD9ED);
        add_step(4'd2,  0, 16'h0003);
        add_step(4'd13, 1, 16'h001E);
        add_step(4'd13, 0, 16'h012C);   // 300
        add_step(4'd11, 0, 16'h012C);
        add_step(4'd2,  2, 16'h0003);
        add_step(4'd13, 0, 16'h001E);
        add_step(4'd14, 0, 16'h001E);   // '#' in mid entry does nothing
        add_step(4'd13, 0, 16'h012C);
        add_step(4'd12, 1, 16'h5F90);   // 90000 mod 2^16
    endtask

    // short presses too brief to pass debounce
    task automatic bounce_key(input calc_pkg::key_idx_t key, input int count);
        int low_len;
        int high_len;
        held_idx = key;
        for (int i = 0; i < count; i++) begin
            low_len  = 1 + ({$random(seed)} % 6);     // at most 6 low cycles
            high_len = 1 + ({$random(seed)} % 3);
            pressed  = 1'b1;
            repeat (low_len) @(negedge clk);
            pressed  = 1'b0;
            repeat (high_len) @(negedge clk);
        end
    endtask

    task automatic press_key(input calc_pkg::key_idx_t key);
        held_idx = key;
        pressed  = 1'b1;
        repeat (40) @(negedge clk);     // long hold still gives one key
        pressed  = 1'b0;
        repeat (40) @(negedge clk);     // released and idle
    endtask

    task automatic pulse_check(input calc_pkg::operand_t exp_val);
        expected = exp_val;
        check    = 1'b1;
        @(negedge clk);
        check    = 1'b0;
    endtask

    initial begin
        nRST     = 1'b0;
        pressed  = 1'b0;
        held_idx = '0;
        check    = 1'b0;
        expected = '0;
        seed     = 32'h75687e9a;
        load_table();
        repeat (8) @(negedge clk);      // reset for 8 cycles
        nRST = 1'b1;
        repeat (20) @(negedge clk);     // idle scan for the startup check
        for (int i = 0; i < step_key.size(); i++) begin
            bounce_key(step_key[i], step_bounce[i]);
            press_key(step_key[i]);
            pulse_check(step_exp[i]);
        end
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", u_chk.checks, u_chk.errors);
        if (u_chk.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // each step takes at most 99 cycles plus reset and startup
    initial begin
        wait (nRST === 1'b1);
        timeout_cycles = step_key.size() * 100 + 8 + 20;
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: stimulus did not finish");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
calc_pkg.sv
key_if.sv
input_control.sv
calc_controller.sv
calc_top.sv
calc_checker.sv
tb_calc.sv
